// File: hdl/motion_pkg.sv
package motion_pkg;

    localparam int data_w = 32;
    localparam int addr_w = 6;
    localparam int num_channels = 4;
    localparam int num_motors = 6;
    localparam int num_endstops = 4;
    localparam int speed_w = 32;
    localparam int default_step_bit = 24;
    localparam int default_x_bits = 20;

    localparam int ch_sel_w = $clog2(num_channels);
    localparam int es_sel_w = $clog2(num_endstops);

    typedef logic [data_w-1:0] reg_word_t;
    typedef logic [15:0] motor_cfg_t;

    // register map
    localparam logic [addr_w-1:0] reg_speed_base = 6'd0; // one per channel
    localparam logic [addr_w-1:0] reg_pre_n = 6'd4;
    localparam logic [addr_w-1:0] reg_pulse_n = 6'd5;
    localparam logic [addr_w-1:0] reg_post_n = 6'd6;
    localparam logic [addr_w-1:0] reg_x_val = 6'd7;
    localparam logic [addr_w-1:0] reg_es_timeout = 6'd8;
    localparam logic [addr_w-1:0] reg_ctrl = 6'd9; // write-only strobes
    localparam logic [addr_w-1:0] reg_motor_cfg_base = 6'd16;
    localparam logic [addr_w-1:0] reg_x_base = 6'd32;
    localparam logic [addr_w-1:0] reg_hold_base = 6'd40;
    localparam logic [addr_w-1:0] reg_es_status = 6'd48;
    localparam logic [addr_w-1:0] reg_overrun = 6'd49;

    localparam int ctrl_clear_bit = 0;
    localparam int ctrl_load_bit = 1;
    localparam int ctrl_unlock_bit = 2;

    // motor config word, field lsbs for the selects
    localparam int cfg_es_sel = 0;
    localparam int cfg_es_en = 2;
    localparam int cfg_ch_sel = 3;
    localparam int cfg_step_en = 5;
    localparam int cfg_invert_dir = 6;
    localparam int cfg_load_sel = 7;
    localparam int cfg_disable = 15;

endpackage

// File: hdl/motion_regs.sv
`timescale 1ns/1ps

module motion_regs import motion_pkg::*; #(
    parameter int X_BITS = default_x_bits
) (
    input  logic clk,
    input  logic rst,
    input  logic wr,
    input  logic [addr_w-1:0] wr_addr,
    input  reg_word_t wr_data,
    input  logic [addr_w-1:0] rd_addr,
    output reg_word_t rd_data,
    input  logic [X_BITS-1:0] x [num_motors],
    input  logic [X_BITS-1:0] x_hold [num_motors],
    input  logic [num_motors-1:0] overrun,
    input  logic [num_endstops-1:0] es_signal,
    input  logic [num_endstops-1:0] es_locked,
    output logic signed [speed_w-1:0] speed [num_channels],
    output reg_word_t pre_n,
    output reg_word_t pulse_n,
    output reg_word_t post_n,
    output logic [X_BITS-1:0] x_val,
    output reg_word_t es_timeout,
    output motor_cfg_t motor_cfg [num_motors],
    output logic clear_x,
    output logic load_x,
    output logic unlock
);

    reg_word_t rd_word;
    logic ctrl_wr;

    assign ctrl_wr = wr && wr_addr == reg_ctrl;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_channels; i++) begin
                speed[i] <= '0;
            end
            for (int i = 0; i < num_motors; i++) begin
                motor_cfg[i] <= '0;
            end
            pre_n <= '0;
            pulse_n <= '0;
            post_n <= '0;
            es_timeout <= '0;
            clear_x <= 1'b0;
            load_x <= 1'b0;
            unlock <= 1'b0;
        end else begin
            // one-cycle strobes from the ctrl register
            clear_x <= ctrl_wr && wr_data[ctrl_clear_bit];
            load_x <= ctrl_wr && wr_data[ctrl_load_bit];
            unlock <= ctrl_wr && wr_data[ctrl_unlock_bit];
            if (wr) begin
                case (wr_addr)
                    reg_pre_n: pre_n <= wr_data;
                    reg_pulse_n: pulse_n <= wr_data;
                    reg_post_n: post_n <= wr_data;
                    reg_es_timeout: es_timeout <= wr_data;
                    default: ;
                endcase
                for (int i = 0; i < num_channels; i++) begin
                    if (wr_addr == reg_speed_base + addr_w'(i)) speed[i] <= $signed(wr_data);
                end
                for (int i = 0; i < num_motors; i++) begin
                    if (wr_addr == reg_motor_cfg_base + addr_w'(i)) motor_cfg[i] <= wr_data[15:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr && wr_addr == reg_x_val) x_val <= wr_data[X_BITS-1:0];
    end

    // readback mux
    always_comb begin
        rd_word = '0;
        for (int i = 0; i < num_motors; i++) begin
            if (rd_addr == reg_x_base + addr_w'(i)) rd_word = data_w'(x[i]);
            if (rd_addr == reg_hold_base + addr_w'(i)) rd_word = data_w'(x_hold[i]);
        end
        if (rd_addr == reg_es_status) begin
            for (int i = 0; i < num_endstops; i++) begin
                rd_word[4*i] = es_signal[i];
                rd_word[4*i+1] = es_locked[i];
            end
        end
        if (rd_addr == reg_overrun) rd_word = data_w'(overrun);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
        end else begin
            rd_data <= rd_word;
        end
    end

endmodule

// File: hdl/speed_integrator.sv
`timescale 1ns/1ps

module speed_integrator import motion_pkg::*; #(
    parameter int STEP_BIT = default_step_bit
) (
    input  logic clk,
    input  logic rst,
    input  logic signed [speed_w-1:0] speed,
    input  logic clear,
    output logic step,
    output logic dir
);

    logic signed [speed_w-1:0] acc;
    logic step_bit_q; // step bit as of last cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
            step_bit_q <= 1'b0;
            step <= 1'b0;
            dir <= 1'b0;
        end else begin
            // any toggle of the step bit is one step
            step <= acc[STEP_BIT] ^ step_bit_q;
            dir <= !speed[speed_w-1]; // high for forward motion
            if (clear) begin
                acc <= '0;
                step_bit_q <= 1'b0;
            end else begin
                acc <= acc + speed; // wraps freely
                step_bit_q <= acc[STEP_BIT];
            end
        end
    end

endmodule

// File: hdl/endstop_debounce.sv
`timescale 1ns/1ps

module endstop_debounce import motion_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic signal_in,
    input  logic unlock,
    input  reg_word_t timeout,
    output logic signal,
    output logic locked,
    output logic hold,
    output logic stb
);

    logic [1:0] sync_q;
    logic in_s;
    reg_word_t cnt;
    reg_word_t cnt_next;
    logic settle;
    logic rise;

    assign in_s = sync_q[1];
    assign cnt_next = cnt + 1'b1;
    assign settle = in_s != signal && cnt_next >= timeout; // new level held long enough
    assign rise = settle && in_s;

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q <= '0;
            cnt <= '0;
            signal <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], signal_in};
            if (in_s == signal) begin
                cnt <= '0;
            end else if (settle) begin
                signal <= in_s;
                cnt <= '0;
            end else begin
                cnt <= cnt_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= 1'b0;
            hold <= 1'b0;
            stb <= 1'b0;
        end else begin
            stb <= rise && !locked;
            if (rise && !locked) begin
                locked <= 1'b1;
                hold <= 1'b1;
            end else if (unlock) begin
                locked <= 1'b0;
                if (!signal) hold <= 1'b0; // release only once the switch is open
            end
        end
    end

endmodule

// File: hdl/motor_channel.sv
`timescale 1ns/1ps

module motor_channel import motion_pkg::*; #(
    parameter int X_BITS = default_x_bits
) (
    input  logic clk,
    input  logic rst,
    input  motor_cfg_t cfg,
    input  logic [num_channels-1:0] ch_step,
    input  logic [num_channels-1:0] ch_dir,
    input  logic [num_endstops-1:0] es_hold,
    input  logic [num_endstops-1:0] es_stb,
    input  reg_word_t pre_n,
    input  reg_word_t pulse_n,
    input  reg_word_t post_n,
    input  logic load_x,
    input  logic [X_BITS-1:0] x_val,
    output logic step,
    output logic dir,
    output logic enable,
    output logic [X_BITS-1:0] x,
    output logic [X_BITS-1:0] x_hold,
    output logic overrun
);

    typedef enum logic [1:0] {
        ph_idle,
        ph_pre,
        ph_pulse,
        ph_post
    } phase_t;

    phase_t phase;
    reg_word_t cnt; // cycles spent in current phase
    logic [ch_sel_w-1:0] ch_sel;
    logic [es_sel_w-1:0] es_sel;
    logic req;
    logic req_dir;
    logic hold_act;
    logic start;
    logic rise;
    logic rise_dir;

    assign ch_sel = cfg[cfg_ch_sel +: ch_sel_w];
    assign es_sel = cfg[cfg_es_sel +: es_sel_w];
    assign req = ch_step[ch_sel] && cfg[cfg_step_en];
    assign req_dir = ch_dir[ch_sel] ^ cfg[cfg_invert_dir];
    assign hold_act = es_hold[es_sel] && cfg[cfg_es_en];
    assign enable = !cfg[cfg_disable];

    assign start = phase == ph_idle && req && !hold_act;

    // step goes high on the coming edge
    assign rise = (start && pre_n == '0) ||
                  (phase == ph_pre && !hold_act && cnt >= pre_n);
    assign rise_dir = start ? req_dir : dir;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= ph_idle;
            cnt <= '0;
            step <= 1'b0;
            dir <= 1'b0;
            overrun <= 1'b0;
        end else begin
            if (req && !hold_act && phase != ph_idle) overrun <= 1'b1; // request dropped
            if (start) dir <= req_dir;
            if (rise) begin
                phase <= ph_pulse;
                step <= 1'b1;
                cnt <= data_w'(1);
            end else begin
                case (phase)
                    ph_idle: begin
                        if (start) begin
                            phase <= ph_pre;
                            cnt <= data_w'(1);
                        end
                    end
                    ph_pre: begin
                        if (hold_act) begin
                            phase <= ph_idle; // endstop hit before the pulse
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    ph_pulse: begin
                        if (cnt >= pulse_n) begin
                            step <= 1'b0;
                            phase <= post_n == '0 ? ph_idle : ph_post;
                            cnt <= data_w'(1);
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    ph_post: begin
                        if (cnt >= post_n) begin
                            phase <= ph_idle;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    default: phase <= ph_idle;
                endcase
            end
        end
    end

    // position moves with the rising edge of step
    always_ff @(posedge clk) begin
        if (rst) begin
            x <= '0;
            x_hold <= '0;
        end else begin
            if (load_x && cfg[cfg_load_sel]) begin
                x <= x_val;
            end else if (rise) begin
                x <= rise_dir ? x + 1'b1 : x - 1'b1;
            end
            if (es_stb[es_sel]) x_hold <= x;
        end
    end

endmodule

// File: hdl/motion_top.sv
`timescale 1ns/1ps

module motion_top import motion_pkg::*; #(
    parameter int STEP_BIT = default_step_bit,
    parameter int X_BITS = default_x_bits
) (
    input  logic clk,
    input  logic rst,
    input  logic wr,
    input  logic [addr_w-1:0] wr_addr,
    input  reg_word_t wr_data,
    input  logic [addr_w-1:0] rd_addr,
    output reg_word_t rd_data,
    input  logic [num_endstops-1:0] endstop,
    output logic [num_motors-1:0] step,
    output logic [num_motors-1:0] dir,
    output logic [num_motors-1:0] enable
);

    logic signed [speed_w-1:0] speed [num_channels];
    reg_word_t pre_n;
    reg_word_t pulse_n;
    reg_word_t post_n;
    reg_word_t es_timeout;
    logic [X_BITS-1:0] x_val;
    motor_cfg_t motor_cfg [num_motors];
    logic clear_x;
    logic load_x;
    logic unlock;
    logic [num_channels-1:0] ch_step;
    logic [num_channels-1:0] ch_dir;
    logic [num_endstops-1:0] es_hold;
    logic [num_endstops-1:0] es_stb;
    logic [num_endstops-1:0] es_signal;
    logic [num_endstops-1:0] es_locked;
    logic [X_BITS-1:0] x [num_motors];
    logic [X_BITS-1:0] x_hold [num_motors];
    logic [num_motors-1:0] overrun;

    motion_regs #(.X_BITS(X_BITS)) regs0 (
        .clk(clk),
        .rst(rst),
        .wr(wr),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .x(x),
        .x_hold(x_hold),
        .overrun(overrun),
        .es_signal(es_signal),
        .es_locked(es_locked),
        .speed(speed),
        .pre_n(pre_n),
        .pulse_n(pulse_n),
        .post_n(post_n),
        .x_val(x_val),
        .es_timeout(es_timeout),
        .motor_cfg(motor_cfg),
        .clear_x(clear_x),
        .load_x(load_x),
        .unlock(unlock)
    );

    for (genvar i = 0; i < num_channels; i++) begin : g_speed
        speed_integrator #(.STEP_BIT(STEP_BIT)) sp (
            .clk(clk),
            .rst(rst),
            .speed(speed[i]),
            .clear(clear_x),
            .step(ch_step[i]),
            .dir(ch_dir[i])
        );
    end

    for (genvar i = 0; i < num_endstops; i++) begin : g_es
        endstop_debounce db (
            .clk(clk),
            .rst(rst),
            .signal_in(endstop[i]),
            .unlock(unlock),
            .timeout(es_timeout),
            .signal(es_signal[i]),
            .locked(es_locked[i]),
            .hold(es_hold[i]),
            .stb(es_stb[i])
        );
    end

    for (genvar i = 0; i < num_motors; i++) begin : g_motor
        motor_channel #(.X_BITS(X_BITS)) mc (
            .clk(clk),
            .rst(rst),
            .cfg(motor_cfg[i]),
            .ch_step(ch_step),
            .ch_dir(ch_dir),
            .es_hold(es_hold),
            .es_stb(es_stb),
            .pre_n(pre_n),
            .pulse_n(pulse_n),
            .post_n(post_n),
            .load_x(load_x),
            .x_val(x_val),
            .step(step[i]),
            .dir(dir[i]),
            .enable(enable[i]),
            .x(x[i]),
            .x_hold(x_hold[i]),
            .overrun(overrun[i])
        );
    end

endmodule

// File: verification/motion_asserts.sv
`timescale 1ns/1ps

module motion_asserts import motion_pkg::*; (
    input logic clk,
    input logic rst,
    input logic step,
    input logic dir,
    input logic hold_act,
    input reg_word_t pulse_n
);

    reg_word_t high_cnt; // cycles step has been high so far
    int fail_cnt = 0;

    always_ff @(posedge clk) begin
        if (rst || !step) begin
            high_cnt <= '0;
        end else begin
            high_cnt <= high_cnt + 1'b1;
        end
    end

    pulse_width: assert property (@(posedge clk) disable iff (rst)
        $fell(step) |-> high_cnt == pulse_n)
    else begin
        $error("step pulse lasted %0d cycles, pulse_n is %0d", high_cnt, pulse_n);
        fail_cnt++;
    end

    // dir may only move while step is low
    dir_stable: assert property (@(posedge clk) disable iff (rst)
        step |=> $stable(dir))
    else begin
        $error("dir changed during a step pulse");
        fail_cnt++;
    end

    no_step_in_hold: assert property (@(posedge clk) disable iff (rst)
        $rose(step) |-> !$past(hold_act))
    else begin
        $error("step rose while the endstop hold was active");
        fail_cnt++;
    end

endmodule

bind motor_channel motion_asserts asrt0 (
    .clk(clk),
    .rst(rst),
    .step(step),
    .dir(dir),
    .hold_act(hold_act),
    .pulse_n(pulse_n)
);

// File: verification/motion_tb.sv
`timescale 1ns/1ps

module motion_tb import motion_pkg::*; ();

    localparam int step_bit = 16; // faster stepping than the default
    localparam int x_bits = default_x_bits;
    localparam int x_mask = (1 << x_bits) - 1;
    localparam int rounds = 2;
    localparam int run_cycles = 2000;
    localparam int settle_cycles = 40;
    localparam int es_cycles = 600;
    localparam int watchdog_cycles = rounds * (run_cycles + 300) + 3 * es_cycles + 1000;

    logic clk;
    logic rst;
    logic wr;
    logic [addr_w-1:0] wr_addr;
    reg_word_t wr_data;
    logic [addr_w-1:0] rd_addr;
    reg_word_t rd_data;
    logic [num_endstops-1:0] endstop;
    logic [num_motors-1:0] step;
    logic [num_motors-1:0] dir;
    logic [num_motors-1:0] enable;

    logic [31:0] rng = 32'd26;
    int count [num_motors] = '{default: 0}; // signed step count per motor
    logic [num_motors-1:0] step_q = '0;
    reg_word_t rd;
    int held;
    int twin_cnt;
    int es_t;
    logic [x_bits-1:0] load_val;

    motion_top #(.STEP_BIT(step_bit), .X_BITS(x_bits)) dut0 (
        .clk(clk),
        .rst(rst),
        .wr(wr),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .endstop(endstop),
        .step(step),
        .dir(dir),
        .enable(enable)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_eq(input string name, input int exp, input int got);
        assert (exp == got)
        else report_failure($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, got));
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond)
        else report_failure(what);
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v ^= v << 13;
        v ^= v >> 17;
        v ^= v << 5;
        return v;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        rng = xorshift(rng);
        return lo + int'(rng % (hi - lo + 1));
    endfunction

    function automatic motor_cfg_t make_cfg(input int ch, input int es, input bit es_en,
                                            input bit step_en, input bit inv, input bit load,
                                            input bit dis);
        motor_cfg_t c;
        c = '0;
        c[cfg_ch_sel +: ch_sel_w] = ch_sel_w'(ch);
        c[cfg_es_sel +: es_sel_w] = es_sel_w'(es);
        c[cfg_es_en] = es_en;
        c[cfg_step_en] = step_en;
        c[cfg_invert_dir] = inv;
        c[cfg_load_sel] = load;
        c[cfg_disable] = dis;
        return c;
    endfunction

    task automatic write_reg(input logic [addr_w-1:0] addr, input reg_word_t data);
        @(posedge clk);
        wr <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        @(posedge clk);
        wr <= 1'b0;
    endtask

    // rd_data is valid one cycle after rd_addr
    task automatic read_reg(input logic [addr_w-1:0] addr, output reg_word_t data);
        @(posedge clk);
        rd_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        data = rd_data;
    endtask

    task automatic check_position(input int m, input string name);
        reg_word_t d;
        read_reg(reg_x_base + addr_w'(m), d);
        check_eq($sformatf("%s x[%0d]", name, m), count[m] & x_mask, int'(d));
    endtask

    task automatic stop_speeds();
        for (int c = 0; c < num_channels; c++) begin
            write_reg(reg_speed_base + addr_w'(c), '0);
        end
        repeat (settle_cycles) @(posedge clk); // let pulses in flight finish
    endtask

    always @(negedge clk) begin
        for (int m = 0; m < num_motors; m++) begin
            if (step[m] && !step_q[m]) count[m] += dir[m] ? 1 : -1;
        end
        step_q = step;
    end

    for (genvar m = 0; m < num_motors; m++) begin : g_watch
        always @(negedge clk) begin
            if (dut0.g_motor[m].mc.asrt0.fail_cnt != 0) begin
                report_failure($sformatf("pulse shape assertion failed in motor %0d", m));
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !step[3])
    else report_failure("motor 3 stepped with its steps disabled");

    assert property (@(posedge clk) disable iff (rst) step[0] && step[1] |-> dir[0] != dir[1])
    else report_failure("inverted twin motors stepped with the same dir");

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        report_failure("watchdog expired before the tests finished");
    end

    initial begin
        rst = 1'b1;
        wr = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_addr = '0;
        endstop = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_eq("reset step", 0, int'(step));
        check_eq("reset dir", 0, int'(dir));
        check_eq("reset enable", (1 << num_motors) - 1, int'(enable));
        for (int m = 0; m < num_motors; m++) begin
            check_position(m, "reset");
            read_reg(reg_hold_base + addr_w'(m), rd);
            check_eq("reset x_hold", 0, int'(rd));
        end
        read_reg(reg_es_status, rd);
        check_eq("reset es_status", 0, int'(rd));
        read_reg(reg_overrun, rd);
        check_eq("reset overrun", 0, int'(rd));

        // 0/1 inverted twins, 2/5 share a channel, 3 disabled
        write_reg(reg_motor_cfg_base + 6'd0, make_cfg(0, 0, 1, 1, 0, 1, 0));
        write_reg(reg_motor_cfg_base + 6'd1, make_cfg(0, 0, 0, 1, 1, 0, 0));
        write_reg(reg_motor_cfg_base + 6'd2, make_cfg(1, 2, 0, 1, 0, 1, 0));
        write_reg(reg_motor_cfg_base + 6'd3, make_cfg(2, 3, 0, 0, 0, 0, 1));
        write_reg(reg_motor_cfg_base + 6'd4, make_cfg(3, 3, 0, 1, 0, 0, 0));
        write_reg(reg_motor_cfg_base + 6'd5, make_cfg(1, 1, 1, 1, 0, 0, 0));
        @(negedge clk);
        check_eq("enable", 6'b110111, int'(enable));

        for (int r = 0; r < rounds; r++) begin
            write_reg(reg_pre_n, rand_range(0, 3));
            write_reg(reg_pulse_n, rand_range(1, 4));
            write_reg(reg_post_n, rand_range(0, 4));
            write_reg(reg_speed_base + 6'd0, rand_range(600, 2100));
            write_reg(reg_speed_base + 6'd1, -rand_range(600, 2100));
            write_reg(reg_speed_base + 6'd2, rand_range(600, 2100));
            write_reg(reg_speed_base + 6'd3, rand_range(600, 2100));
            repeat (run_cycles) @(posedge clk);
            stop_speeds();
            for (int m = 0; m < num_motors; m++) begin
                check_position(m, "tracking");
            end
            check_eq("shared channel count", count[2], count[5]);
            check_eq("inverted twin count", -count[0], count[1]);
            check_eq("disabled motor count", 0, count[3]);
            check_true(count[0] > 0 && count[4] > 0,
                       "a motor on a positive speed did not count up");
            check_true(count[2] < 0, "motor 2 did not count down on a negative speed");
            read_reg(reg_overrun, rd);
            check_eq("overrun at low speed", 0, int'(rd));
        end

        // steps on back-to-back cycles on channel 3
        write_reg(reg_speed_base + 6'd3, 3 << (step_bit - 2));
        repeat (100) @(posedge clk);
        stop_speeds();
        read_reg(reg_overrun, rd);
        check_eq("overrun", 1 << 4, int'(rd));
        check_position(4, "overrun");

        es_t = rand_range(4, 11);
        write_reg(reg_es_timeout, es_t);
        write_reg(reg_speed_base + 6'd0, rand_range(1500, 2100));
        @(posedge clk);
        endstop[0] <= 1'b1;
        repeat (es_t - 2) @(posedge clk);
        endstop[0] <= 1'b0;
        repeat (20) @(posedge clk);
        read_reg(reg_es_status, rd);
        check_eq("short endstop pulse", 0, int'(rd));

        @(posedge clk);
        endstop[0] <= 1'b1;
        do begin
            read_reg(reg_es_status, rd);
        end while (rd[1] == 1'b0);
        check_eq("endstop status", 3, int'(rd));
        repeat (settle_cycles) @(posedge clk);
        read_reg(reg_hold_base + 6'd0, rd);
        held = int'(rd);
        check_position(0, "endstop stop");
        twin_cnt = count[1];
        repeat (es_cycles) @(posedge clk);
        read_reg(reg_x_base + 6'd0, rd);
        check_eq("x frozen at x_hold", held, int'(rd));
        check_true(count[1] != twin_cnt, "motor without endstop enable stopped at the endstop");

        @(posedge clk);
        endstop[0] <= 1'b0;
        do begin
            read_reg(reg_es_status, rd);
        end while (rd[0] == 1'b1);
        write_reg(reg_ctrl, 1 << ctrl_unlock_bit);
        repeat (es_cycles) @(posedge clk);
        stop_speeds();
        read_reg(reg_es_status, rd);
        check_eq("status after unlock", 0, int'(rd));
        read_reg(reg_x_base + 6'd0, rd);
        check_true(int'(rd) != held, "motor 0 did not resume after unlock");
        check_position(0, "after unlock");

        load_val = x_bits'(rand_range(1, x_mask));
        write_reg(reg_x_val, load_val);
        write_reg(reg_ctrl, 1 << ctrl_load_bit);
        for (int m = 0; m < num_motors; m++) begin
            if (m == 0 || m == 2) begin
                read_reg(reg_x_base + addr_w'(m), rd);
                check_eq($sformatf("load x[%0d]", m), int'(load_val), int'(rd));
            end else begin
                check_position(m, "load kept");
            end
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: list.f
hdl/motion_pkg.sv
hdl/motion_regs.sv
hdl/speed_integrator.sv
hdl/endstop_debounce.sv
hdl/motor_channel.sv
hdl/motion_top.sv
verification/motion_asserts.sv
verification/motion_tb.sv

// File: Bender.yml
package:
  name: motion_core

sources:
  - files:
      - hdl/motion_pkg.sv
      - hdl/motion_regs.sv
      - hdl/speed_integrator.sv
      - hdl/endstop_debounce.sv
      - hdl/motor_channel.sv
      - hdl/motion_top.sv
  - target: test
    files:
      - verification/motion_asserts.sv
      - verification/motion_tb.sv
